/* all.f */
rtl/vicPkg.sv
rtl/vicRegIf.sv
rtl/vicApbSlave.sv
rtl/vicIntRegs.sv
rtl/vicPortConfig.sv
rtl/vicIrqOutput.sv
rtl/vicTop.sv
dv/vicTb.sv

/* dv/vicTb.sv */
// Testbench for the interrupt controller register block with APB tasks, checks and timeout
`timescale 1ns/1ns

module vicTb import vicPkg::*; ();

   localparam int timeoutCycles = 2000;

   logic                      clk;
   logic                      reg_reset;
   apbAddrT                   paddr;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   regDataT                   pwdata;
   regDataT                   prdata;
   logic                      pready;
   logic                      pslverr;
   irqVecT                    irqIn;
   irqVecT                    irqValid;
   portRecordT [numPorts-1:0] irqData;

   confWordT cfgModel [numPorts];
   integer   seed;
   int       errCount;
   int       errAtStart;
   int       passCount;
   int       failCount;
   int       cycleCnt;

   vicTop uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Cycle limit for a stalled run
   always @(posedge clk) begin
      cycleCnt++;
      if (cycleCnt >= timeoutCycles) begin
         $display("Simulation timed out after %0d cycles without finishing the tests", cycleCnt);
         $display("Simulation failed");
         $finish;
      end
   end

   // **************************************************************************
   // Helpers

   function automatic apbAddrT regAddr(input int idx);
      return apbAddrT'(idx * 4);
   endfunction

   task automatic stepCycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // One setup cycle and two access cycles before the bus is released
   task automatic apbXfer(input logic wr, input apbAddrT addr, input regDataT wdata,
                          output regDataT rdata, output logic err);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      stepCycles(1);
      penable = 1'b1;
      checkEq(pready, 1'b0, "pready in first access cycle");
      stepCycles(1);
      checkEq(pready, 1'b1, "pready in second access cycle");
      while (!pready) stepCycles(1);
      rdata = prdata;
      err   = pslverr;
      stepCycles(1);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apbWrite(input apbAddrT addr, input regDataT wdata, output logic err);
      regDataT unused;
      apbXfer(1'b1, addr, wdata, unused, err);
   endtask

   task automatic apbRead(input apbAddrT addr, output regDataT rdata, output logic err);
      apbXfer(1'b0, addr, '0, rdata, err);
   endtask

   task automatic checkEq(input regDataT got, input regDataT exp, input string what);
      assert (got === exp) else begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errCount++;
      end
   endtask

   // Readback with pslverr expected low
   task automatic readCheck(input int idx, input regDataT exp, input string what);
      regDataT rd;
      logic    err;
      apbRead(regAddr(idx), rd, err);
      checkEq(rd, exp, what);
      checkEq(err, 1'b0, {what, " pslverr"});
   endtask

   task automatic checkOutputs(input irqVecT expValid);
      regDataT expRec;
      checkEq(irqValid, expValid, "irqValid");
      for (int k = 0; k < numPorts; k++) begin
         expRec = expValid[k] ? ((k << confWordW) | cfgModel[k]) : '0;
         checkEq(irqData[k], expRec, $sformatf("irqData[%0d]", k));
      end
   endtask

   task automatic errAccess(input logic wr, input int idx);
      regDataT rd;
      logic    err;
      apbXfer(wr, regAddr(idx), 32'hFFFF_FFFF, rd, err);
      checkEq(err, 1'b1, $sformatf("pslverr at index %0d", idx));
      checkEq(rd, '0, $sformatf("read data at index %0d", idx));
   endtask

   task automatic finishTest(input string name);
      if (errCount == errAtStart) begin
         passCount++;
         $display("Test %s passed", name);
      end else begin
         failCount++;
         $display("Test %s failed with %0d errors", name, errCount - errAtStart);
      end
      errAtStart = errCount;
   endtask

   // **************************************************************************
   // Stimulus

   initial begin
      regDataT val;
      logic    err;
      irqVecT  irqVal;
      irqVecT  enModel;
      irqVecT  trigModel;
      seed      = 32'h303edf37;
      reg_reset = 1'b1;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      irqIn     = '0;
      enModel   = '0;
      trigModel = '0;
      repeat (5) @(posedge clk);
      #1;
      reg_reset = 1'b0;

      // Whole config table written before any readback so aliasing shows up
      for (int k = 0; k < numPorts; k++) begin
         val = $random(seed);
         cfgModel[k] = val[confWordW-1:0];
         apbWrite(regAddr(k), val, err);
         checkEq(err, 1'b0, "config write pslverr");
      end
      for (int k = 0; k < numPorts; k++) readCheck(k, cfgModel[k], $sformatf("config %0d", k));
      finishTest("config table");

      // Enable aliases
      for (int op = 0; op < 3; op++) begin
         irqVal = $random(seed);
         apbWrite(regAddr(idxEnable + op), irqVal, err);
         enModel = (op == 0) ? irqVal : (op == 1) ? (enModel | irqVal) : (enModel & ~irqVal);
         for (int a = 0; a < 3; a++) readCheck(idxEnable + a, enModel, "enable");
      end
      finishTest("enable register");

      for (int i = 0; i < 4; i++) begin
         irqVal  = $random(seed);
         enModel = $random(seed);
         irqIn   = irqVal;
         apbWrite(regAddr(idxEnable), enModel, err);
         readCheck(idxRawStatus, irqVal, "raw status");
         readCheck(idxPending, enModel & irqVal, "pending");
      end
      finishTest("raw status and pending");

      // Output records appear three edges after the input changes
      for (int p = 0; p < 2; p++) begin
         irqIn   = '0;
         enModel = (p == 0) ? 8'hA5 : 8'hFF;
         irqVal  = (p == 0) ? 8'h6F : $random(seed);
         apbWrite(regAddr(idxEnable), enModel, err);
         stepCycles(3);
         checkOutputs('0);
         irqIn = irqVal;
         stepCycles(2);
         checkOutputs('0);
         for (int c = 0; c < 6; c++) begin
            stepCycles(1);
            checkOutputs(enModel & irqVal);
         end
      end
      finishTest("output records");

      irqIn   = '0;
      enModel = 8'h3C;
      apbWrite(regAddr(idxEnable), enModel, err);
      apbWrite(regAddr(idxSwTrigSet), 32'h0F, err);
      apbWrite(regAddr(idxSwTrigSet), 32'h30, err);
      trigModel = 8'h3F;
      readCheck(idxSwTrig, trigModel, "software trigger");
      readCheck(idxPending, enModel & trigModel, "pending from trigger");
      checkOutputs(enModel & trigModel);
      apbWrite(regAddr(idxSwTrigClr), 32'h3F, err);
      trigModel = '0;
      readCheck(idxSwTrigClr, trigModel, "software trigger after clear");
      readCheck(idxPending, '0, "pending after clear");
      checkOutputs('0);
      finishTest("software trigger");

      // Holes and read-only targets leave their neighbors unchanged
      irqIn = 8'h5A;
      errAccess(1'b0, 8);
      errAccess(1'b1, 8);
      errAccess(1'b0, 27);
      errAccess(1'b1, 27);
      errAccess(1'b1, idxPending);
      errAccess(1'b1, idxRawStatus);
      readCheck(0, cfgModel[0], "config 0 after errors");
      readCheck(7, cfgModel[7], "config 7 after errors");
      readCheck(idxEnable, enModel, "enable after errors");
      readCheck(idxSwTrig, trigModel, "software trigger after errors");
      readCheck(idxRawStatus, 8'h5A, "raw status after errors");
      readCheck(idxPending, enModel & 8'h5A, "pending after errors");
      finishTest("error responses");

      $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
      if (errCount == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* rtl/vicTop.sv */
// Interrupt controller register block top with APB access and output records
`timescale 1ns/1ns

module vicTop import vicPkg::*; (
   input  logic                      clk,
   input  logic                      reg_reset,

   // APB
   input  apbAddrT                   paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  regDataT                   pwdata,
   output regDataT                   prdata,
   output logic                      pready,
   output logic                      pslverr,

   // Interrupts
   input  irqVecT                    irqIn,
   output irqVecT                    irqValid,
   output portRecordT [numPorts-1:0] irqData
);

   irqVecT                  pending;
   confWordT [numPorts-1:0] configTable;

   vicRegIf regBus ();

   vicApbSlave uApb (
      .clk       (clk),
      .reg_reset (reg_reset),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .regBus    (regBus.master)
   );

   vicIntRegs uIntRegs (
      .clk       (clk),
      .reg_reset (reg_reset),
      .regBus    (regBus.ctrl),
      .irqIn     (irqIn),
      .pending   (pending)
   );

   vicPortConfig uPortConfig (
      .clk         (clk),
      .reg_reset   (reg_reset),
      .regBus      (regBus.conf),
      .configTable (configTable)
   );

   vicIrqOutput uIrqOutput (
      .clk         (clk),
      .reg_reset   (reg_reset),
      .pending     (pending),
      .configTable (configTable),
      .irqValid    (irqValid),
      .irqData     (irqData)
   );

endmodule

/* rtl/vicIrqOutput.sv */
// Registered per-port output records built from pending bits and config words
`timescale 1ns/1ns

module vicIrqOutput import vicPkg::*; (
   input  logic                      clk,
   input  logic                      reg_reset,
   input  irqVecT                    pending,
   input  confWordT   [numPorts-1:0] configTable,
   output irqVecT                    irqValid,
   output portRecordT [numPorts-1:0] irqData
);

   for (genvar k = 0; k < numPorts; k++) begin : genPort
      logic       validQ;
      portRecordT dataQ;

      // Record is cleared while the port is idle
      always_ff @(posedge clk) begin
         if (reg_reset) begin
            validQ <= 1'b0;
            dataQ  <= '0;
         end else begin
            validQ <= pending[k];
            dataQ  <= pending[k] ? {portIdT'(k), configTable[k]} : '0;
         end
      end

      assign irqValid[k] = validQ;
      assign irqData[k]  = dataQ;
   end

endmodule

/* rtl/vicPortConfig.sv */
// Per-port configuration word table with write and readback
`timescale 1ns/1ns

module vicPortConfig import vicPkg::*; (
   input  logic                    clk,
   input  logic                    reg_reset,
   vicRegIf.conf                   regBus,
   output confWordT [numPorts-1:0] configTable
);

   logic [portIdxW-1:0] portSel;
   confWordT            wrWord;

   // Block range is already decoded, only the port number is left
   assign portSel = regBus.regIndex[portIdxW-1:0];

   // Upper write bits are dropped
   assign wrWord = regBus.wrData[confWordW-1:0];

   // **************************************************************************
   // Table

   always_ff @(posedge clk) begin
      if (reg_reset) begin
         configTable <= '0;
      end else if (regBus.wrEn && regBus.confSel) begin
         configTable[portSel] <= wrWord;
      end
   end

   // Zero-extended to the bus width
   assign regBus.confRdData = (regBus.rdEn && regBus.confSel) ?
                              regDataT'(configTable[portSel]) : '0;

endmodule

/* rtl/vicIntRegs.sv */
// Interrupt input sampling, enable, software trigger, raw status and pending registers
`timescale 1ns/1ns

module vicIntRegs import vicPkg::*; (
   input  logic   clk,
   input  logic   reg_reset,
   vicRegIf.ctrl  regBus,
   input  irqVecT irqIn,
   output irqVecT pending
);

   irqVecT irqSample;
   irqVecT rawStatus;
   irqVecT enable;
   irqVecT swTrig;
   irqVecT wrBits;
   irqVecT rdMux;

   // Overwrite, set or clear depending on which alias was hit
   function automatic irqVecT aliasWrite(
      input irqVecT   cur,
      input irqVecT   data,
      input regIndexT idx,
      input regIndexT wrIdx,
      input regIndexT setIdx,
      input regIndexT clrIdx
   );
      irqVecT res;
      res = cur;
      if (idx == wrIdx) begin
         res = data;
      end else if (idx == setIdx) begin
         res = cur | data;
      end else if (idx == clrIdx) begin
         res = cur & ~data;
      end
      return res;
   endfunction

   assign wrBits = regBus.wrData[numPorts-1:0];

   // **************************************************************************
   // Sample, status and pending pipeline

   always_ff @(posedge clk) begin
      if (reg_reset) begin
         irqSample <= '0;
         rawStatus <= '0;
         pending   <= '0;
         enable    <= '0;
         swTrig    <= '0;
      end else begin
         irqSample <= irqIn;
         rawStatus <= irqSample;
         pending   <= enable & (irqSample | swTrig);
         if (regBus.wrEn && regBus.ctrlSel) begin
            enable <= aliasWrite(enable, wrBits, regBus.regIndex,
                                 idxEnable, idxEnableSet, idxEnableClr);
            swTrig <= aliasWrite(swTrig, wrBits, regBus.regIndex,
                                 idxSwTrig, idxSwTrigSet, idxSwTrigClr);
         end
      end
   end

   // **************************************************************************
   // Readback

   always_comb begin
      case (regBus.regIndex)
         idxEnable, idxEnableSet, idxEnableClr: rdMux = enable;
         idxPending:                            rdMux = pending;
         idxRawStatus:                          rdMux = rawStatus;
         idxSwTrig, idxSwTrigSet, idxSwTrigClr: rdMux = swTrig;
         default:                               rdMux = '0;
      endcase
   end

   assign regBus.ctrlRdData = (regBus.rdEn && regBus.ctrlSel) ? regDataT'(rdMux) : '0;

endmodule

/* rtl/vicApbSlave.sv */
// APB slave FSM with address decode, error flagging and read data capture
`timescale 1ns/1ns

module vicApbSlave import vicPkg::*; (
   input  logic    clk,
   input  logic    reg_reset,
   input  apbAddrT paddr,
   input  logic    psel,
   input  logic    penable,
   input  logic    pwrite,
   input  regDataT pwdata,
   output regDataT prdata,
   output logic    pready,
   output logic    pslverr,
   vicRegIf.master regBus
);

   typedef enum logic [1:0] {stIdle, stAccess, stDone} apbStateT;

   apbStateT state;
   regIndexT wordIdx;
   logic     inAccess;
   logic     outOfMap;
   logic     roWrite;
   logic     accErr;

   // **************************************************************************
   // Decode

   assign wordIdx  = paddr[regIndexW+1:2];
   assign inAccess = (state == stAccess);

   // Holes at 8-15 and 24-31, anything above 0x7F as well
   assign outOfMap = paddr[apbAddrW-1] | wordIdx[3];
   assign roWrite  = pwrite && ((wordIdx == idxPending) || (wordIdx == idxRawStatus));
   assign accErr   = outOfMap | roWrite;

   assign regBus.regIndex = wordIdx;
   assign regBus.wrData   = pwdata;
   assign regBus.confSel  = !outOfMap && (wordIdx[4:3] == 2'b00);
   assign regBus.ctrlSel  = !outOfMap && (wordIdx[4:3] == 2'b10);
   assign regBus.wrEn     = inAccess && pwrite && !accErr;
   assign regBus.rdEn     = inAccess && !pwrite && !accErr;

   // **************************************************************************
   // Transfer sequencing, one setup then two access cycles

   always_ff @(posedge clk) begin
      if (reg_reset) begin
         state <= stIdle;
      end else begin
         case (state)
            stIdle:   if (psel && !penable) state <= stAccess;
            stAccess: state <= stDone;
            default:  state <= stIdle;
         endcase
      end
   end

   // Unselected blocks return zero, so the two read buses can be merged
   always_ff @(posedge clk) begin
      if (reg_reset) begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end else if (inAccess) begin
         prdata  <= regBus.ctrlRdData | regBus.confRdData;
         pslverr <= accErr;
      end else begin
         pslverr <= 1'b0;
      end
   end

   assign pready = (state == stDone);

endmodule

/* rtl/vicRegIf.sv */
// Internal register access interface between the APB slave and the register blocks
`timescale 1ns/1ns

interface vicRegIf import vicPkg::*; ();

   // One-cycle strobes
   logic     wrEn;
   logic     rdEn;
   regIndexT regIndex;
   regDataT  wrData;

   // Block selects from the central decode
   logic     ctrlSel;
   logic     confSel;

   // Read data, zero unless the block is selected for a read
   regDataT  ctrlRdData;
   regDataT  confRdData;

   modport master (
      output wrEn, rdEn, regIndex, wrData, ctrlSel, confSel,
      input  ctrlRdData, confRdData
   );

   modport ctrl (input wrEn, rdEn, regIndex, wrData, ctrlSel, output ctrlRdData);

   modport conf (input wrEn, rdEn, regIndex, wrData, confSel, output confRdData);

endinterface

/* rtl/vicPkg.sv */
// Port count, field widths, vector types and register map of the interrupt controller

package vicPkg;

   // **************************************************************************
   // Sizes

   localparam int numPorts  = 8;
   localparam int portIdxW  = $clog2(numPorts);
   localparam int regDataW  = 32;
   localparam int apbAddrW  = 8;
   localparam int regIndexW = 5;
   localparam int portIdW   = 6;
   localparam int confWordW = 13;

   typedef logic [numPorts-1:0]          irqVecT;
   typedef logic [regDataW-1:0]          regDataT;
   typedef logic [apbAddrW-1:0]          apbAddrT;
   typedef logic [regIndexW-1:0]         regIndexT;
   typedef logic [portIdW-1:0]           portIdT;

   // Register set [12:7], NMI [6], level [5:0]
   typedef logic [confWordW-1:0]         confWordT;

   // Port id above the config word
   typedef logic [portIdW+confWordW-1:0] portRecordT;

   // **************************************************************************
   // Control block word indices, config words sit at 0 to 7

   localparam regIndexT idxEnable    = 5'd16;
   localparam regIndexT idxEnableSet = 5'd17;
   localparam regIndexT idxEnableClr = 5'd18;
   localparam regIndexT idxPending   = 5'd19;
   localparam regIndexT idxRawStatus = 5'd20;
   localparam regIndexT idxSwTrig    = 5'd21;
   localparam regIndexT idxSwTrigSet = 5'd22;
   localparam regIndexT idxSwTrigClr = 5'd23;

endpackage
